//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int BE_W       = XLEN / 8;
    localparam int TRANS_ID_W = 3;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [BE_W-1:0]       be_t;
    typedef logic [TRANS_ID_W-1:0] trans_id_t;
    typedef logic [3:0]            cause_t;

    // exception causes, as in mcause
    localparam cause_t CAUSE_LD_MISALIGNED = 4'd4;
    localparam cause_t CAUSE_LD_ACCESS     = 4'd5;
    localparam cause_t CAUSE_ST_MISALIGNED = 4'd6;
    localparam cause_t CAUSE_ST_ACCESS     = 4'd7;

    // --------------------------------------------------
    // operation encoding
    // --------------------------------------------------
    // bit 3 store, bits 2:1 size, bit 0 unsigned
    localparam int OP_STORE_BIT    = 3;
    localparam int OP_UNSIGNED_BIT = 0;

    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LBU = 4'b0001,
        OP_LH  = 4'b0010,
        OP_LHU = 4'b0011,
        OP_LW  = 4'b0100,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1010,
        OP_SW  = 4'b1100
    } lsu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } lsu_state_e;

    // bus timeout, in ACCESS cycles
    localparam int ACCESS_TIMEOUT = 16;
    localparam int TIMER_W        = 5;

endpackage

`default_nettype wire

//--- verilog/lsu_agu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_agu
    import lsu_pkg::*;
(
    input  lsu_op_e op_i,
    input  addr_t   base_i,
    input  data_t   imm_i,
    input  data_t   store_data_i,
    output addr_t   addr_o,
    output be_t     be_o,
    output data_t   wdata_o,
    output logic    misaligned_o
);

    logic [1:0] size;

    // immediate arrives already sign extended
    assign addr_o = base_i + imm_i;
    assign size   = op_i[2:1];

    // --------------------------------------------------
    // byte enables and store lanes
    // --------------------------------------------------
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                be_o    = be_t'(4'b0001) << addr_o[1:0];
                wdata_o = {4{store_data_i[7:0]}};
            end
            SIZE_HALF: begin
                // odd halfword still gets a lane pair, it never reaches the bus
                be_o    = be_t'(4'b0011) << {addr_o[1], 1'b0};
                wdata_o = {2{store_data_i[15:0]}};
            end
            default: begin
                be_o    = '1;
                wdata_o = store_data_i;
            end
        endcase
    end

    // --------------------------------------------------
    // misalignment
    // --------------------------------------------------
    always_comb begin
        case (size)
            SIZE_BYTE: misaligned_o = 1'b0;
            SIZE_HALF: misaligned_o = addr_o[0];
            default:   misaligned_o = (addr_o[1:0] != 2'b00);
        endcase
    end

    // every transfer touches at least one lane
    always_comb begin
        if (!$isunknown(be_o)) begin
            be_nonzero: assert (be_o != '0)
                else $error("lsu_agu: empty byte enable for op %s", op_i.name());
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_wait_timer.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_wait_timer
    import lsu_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic active_i,
    output logic timeout_o
);

    logic [TIMER_W-1:0] count_q;

    // counts ACCESS cycles, cleared between accesses
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (!active_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign timeout_o = active_i && (count_q == TIMER_W'(ACCESS_TIMEOUT - 1));

    // the FSM must leave ACCESS once the timer fires
    count_bounded: assert property (@(posedge clk_i) disable iff (!rst_ni)
        count_q <= TIMER_W'(ACCESS_TIMEOUT))
        else $error("lsu_wait_timer: access ran past the timeout");

endmodule

`default_nettype wire

//--- verilog/lsu_load_align.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_load_align
    import lsu_pkg::*;
(
    input  lsu_op_e    op_i,
    input  logic [1:0] addr_lsb_i,
    input  data_t      rdata_i,
    output data_t      data_o
);

    data_t shifted;
    logic  is_unsigned;

    // addressed lane down to bit 0
    assign shifted     = rdata_i >> {addr_lsb_i, 3'b000};
    assign is_unsigned = op_i[OP_UNSIGNED_BIT];

    always_comb begin
        case (op_i[2:1])
            SIZE_BYTE: begin
                if (is_unsigned) begin
                    data_o = {{(XLEN-8){1'b0}}, shifted[7:0]};
                end else begin
                    data_o = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
                end
            end
            SIZE_HALF: begin
                if (is_unsigned) begin
                    data_o = {{(XLEN-16){1'b0}}, shifted[15:0]};
                end else begin
                    data_o = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
                end
            end
            // full word, aligned so no shift
            default: data_o = shifted;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/lsu_access_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_access_fsm
    import lsu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    // issue
    input  logic       lsu_valid_i,
    input  lsu_op_e    op_i,
    input  trans_id_t  trans_id_i,
    output logic       lsu_ready_o,
    // from the AGU
    input  addr_t      addr_i,
    input  be_t        be_i,
    input  data_t      wdata_i,
    input  logic       misaligned_i,
    // load path
    input  data_t      load_data_i,
    output lsu_op_e    op_q_o,
    output logic [1:0] addr_lsb_o,
    // writeback
    output logic       result_valid_o,
    output trans_id_t  result_trans_id_o,
    output data_t      result_data_o,
    output logic       ex_valid_o,
    output cause_t     ex_cause_o,
    output addr_t      ex_tval_o,
    // APB master
    output addr_t      paddr_o,
    output logic       psel_o,
    output logic       penable_o,
    output logic       pwrite_o,
    output data_t      pwdata_o,
    output be_t        pstrb_o,
    input  logic       pready_i,
    input  logic       pslverr_i,
    // timer
    output logic       access_o,
    input  logic       timeout_i
);

    lsu_state_e state_q, state_d;
    logic       accept;
    logic       access_done;
    logic       fault;
    logic       ex_q;

    lsu_op_e    op_q;
    trans_id_t  trans_id_q;
    addr_t      addr_q;
    be_t        be_q;
    data_t      wdata_q;
    data_t      data_q;
    cause_t     cause_q;

    assign accept      = lsu_valid_i && (state_q == IDLE);
    assign access_done = (state_q == ACCESS) && (pready_i || timeout_i);
    // timeout without pready counts as a fault too
    assign fault       = pslverr_i || !pready_i;

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (lsu_valid_i) state_d = misaligned_i ? RESP : SETUP;
            SETUP:   state_d = ACCESS;
            ACCESS:  if (pready_i || timeout_i) state_d = RESP;
            RESP:    state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            ex_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                ex_q <= misaligned_i;
            end else if (access_done) begin
                ex_q <= fault;
            end
        end
    end

    // request capture and result
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q       <= op_i;
            trans_id_q <= trans_id_i;
            addr_q     <= addr_i;
            be_q       <= be_i;
            wdata_q    <= wdata_i;
            data_q     <= '0;
            cause_q    <= op_i[OP_STORE_BIT] ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
        end else if (access_done) begin
            data_q  <= (fault || op_q[OP_STORE_BIT]) ? '0 : load_data_i;
            cause_q <= op_q[OP_STORE_BIT] ? CAUSE_ST_ACCESS : CAUSE_LD_ACCESS;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign lsu_ready_o       = (state_q == IDLE);
    assign result_valid_o    = (state_q == RESP);
    assign result_trans_id_o = trans_id_q;
    assign result_data_o     = data_q;
    assign ex_valid_o        = (state_q == RESP) && ex_q;
    assign ex_cause_o        = cause_q;
    assign ex_tval_o         = addr_q;

    assign psel_o    = (state_q == SETUP) || (state_q == ACCESS);
    assign penable_o = (state_q == ACCESS);
    assign paddr_o   = addr_q;
    assign pwrite_o  = op_q[OP_STORE_BIT];
    assign pwdata_o  = wdata_q;
    assign pstrb_o   = op_q[OP_STORE_BIT] ? be_q : '0;

    assign access_o   = (state_q == ACCESS);
    assign op_q_o     = op_q;
    assign addr_lsb_o = addr_q[1:0];

    penable_in_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_o |-> psel_o)
        else $error("lsu_access_fsm: penable without psel");

    // slave sees a steady request for the whole access phase
    apb_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        penable_o |-> $stable({paddr_o, pwrite_o, pwdata_o, pstrb_o}))
        else $error("lsu_access_fsm: APB request changed during ACCESS");

    result_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        result_valid_o |=> !result_valid_o)
        else $error("lsu_access_fsm: result held longer than one cycle");

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    // issue from execute
    input  logic      lsu_valid_i,
    output logic      lsu_ready_o,
    input  lsu_op_e   op_i,
    input  addr_t     base_i,
    input  data_t     imm_i,
    input  data_t     store_data_i,
    input  trans_id_t trans_id_i,
    // writeback
    output logic      result_valid_o,
    output trans_id_t result_trans_id_o,
    output data_t     result_data_o,
    output logic      ex_valid_o,
    output cause_t    ex_cause_o,
    output addr_t     ex_tval_o,
    // APB master
    output addr_t     paddr_o,
    output logic      psel_o,
    output logic      penable_o,
    output logic      pwrite_o,
    output data_t     pwdata_o,
    output be_t       pstrb_o,
    input  data_t     prdata_i,
    input  logic      pready_i,
    input  logic      pslverr_i
);

    addr_t      agu_addr;
    be_t        agu_be;
    data_t      agu_wdata;
    logic       agu_misaligned;
    data_t      load_data;
    lsu_op_e    op_q;
    logic [1:0] addr_lsb;
    logic       access_active;
    logic       timeout;

    // --------------------------------------------------
    // address generation
    // --------------------------------------------------
    lsu_agu i_agu (
        .op_i         ( op_i           ),
        .base_i       ( base_i         ),
        .imm_i        ( imm_i          ),
        .store_data_i ( store_data_i   ),
        .addr_o       ( agu_addr       ),
        .be_o         ( agu_be         ),
        .wdata_o      ( agu_wdata      ),
        .misaligned_o ( agu_misaligned )
    );

    // --------------------------------------------------
    // bus sequencing
    // --------------------------------------------------
    lsu_access_fsm i_access_fsm (
        .clk_i             ( clk_i             ),
        .rst_ni            ( rst_ni            ),
        .lsu_valid_i       ( lsu_valid_i       ),
        .op_i              ( op_i              ),
        .trans_id_i        ( trans_id_i        ),
        .lsu_ready_o       ( lsu_ready_o       ),
        .addr_i            ( agu_addr          ),
        .be_i              ( agu_be            ),
        .wdata_i           ( agu_wdata         ),
        .misaligned_i      ( agu_misaligned    ),
        .load_data_i       ( load_data         ),
        .op_q_o            ( op_q              ),
        .addr_lsb_o        ( addr_lsb          ),
        .result_valid_o    ( result_valid_o    ),
        .result_trans_id_o ( result_trans_id_o ),
        .result_data_o     ( result_data_o     ),
        .ex_valid_o        ( ex_valid_o        ),
        .ex_cause_o        ( ex_cause_o        ),
        .ex_tval_o         ( ex_tval_o         ),
        .paddr_o           ( paddr_o           ),
        .psel_o            ( psel_o            ),
        .penable_o         ( penable_o         ),
        .pwrite_o          ( pwrite_o          ),
        .pwdata_o          ( pwdata_o          ),
        .pstrb_o           ( pstrb_o           ),
        .pready_i          ( pready_i          ),
        .pslverr_i         ( pslverr_i         ),
        .access_o          ( access_active     ),
        .timeout_i         ( timeout           )
    );

    lsu_wait_timer i_wait_timer (
        .clk_i     ( clk_i         ),
        .rst_ni    ( rst_ni        ),
        .active_i  ( access_active ),
        .timeout_o ( timeout       )
    );

    // read data straight off the bus
    lsu_load_align i_load_align (
        .op_i       ( op_q      ),
        .addr_lsb_i ( addr_lsb  ),
        .rdata_i    ( prdata_i  ),
        .data_o     ( load_data )
    );

endmodule

`default_nettype wire

//--- verification/tb_apb_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_apb_mem
    import lsu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  addr_t      paddr_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  data_t      pwdata_i,
    input  be_t        pstrb_i,
    output data_t      prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    // per-operation bus behavior
    input  logic [7:0] wait_states_i,
    input  logic       error_i
);

    localparam int WORDS = 64;
    localparam int IDX_W = 6;

    data_t            mem [WORDS];
    logic [7:0]       wait_q;
    logic [IDX_W-1:0] index;
    logic             access;

    assign index     = paddr_i[IDX_W+1:2];
    assign access    = psel_i && penable_i;
    assign pready_o  = access && (wait_q == wait_states_i);
    assign pslverr_o = pready_o && error_i;
    assign prdata_o  = mem[index];

    // ACCESS cycles seen so far in this transfer
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wait_q <= '0;
        end else if (!access || pready_o) begin
            wait_q <= '0;
        end else begin
            wait_q <= wait_q + 8'd1;
        end
    end

    // fill pattern follows the byte address, errored writes are dropped
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= 32'h5A5A_0000 + data_t'(i * 4);
            end
        end else if (pready_o && pwrite_i && !error_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (pstrb_i[b]) begin
                    mem[index][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lsu
    import lsu_pkg::*;
();

    localparam string STIM_FILE    = "verification/lsu_stimulus.txt";
    localparam int    RESET_CYCLES = 8;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       lsu_valid;
    logic       lsu_ready;
    lsu_op_e    op;
    addr_t      base;
    data_t      imm;
    data_t      store_data;
    trans_id_t  trans_id;
    logic       result_valid;
    trans_id_t  result_trans_id;
    data_t      result_data;
    logic       ex_valid;
    cause_t     ex_cause;
    addr_t      ex_tval;
    addr_t      paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    data_t      pwdata;
    be_t        pstrb;
    data_t      prdata;
    logic       pready;
    logic       pslverr;
    logic [7:0] mem_wait;
    logic       mem_error;
    int         n_ops = 0;

    always #10 clk = ~clk;

    lsu_top uut (
        .clk_i             ( clk             ),
        .rst_ni            ( rst_n           ),
        .lsu_valid_i       ( lsu_valid       ),
        .lsu_ready_o       ( lsu_ready       ),
        .op_i              ( op              ),
        .base_i            ( base            ),
        .imm_i             ( imm             ),
        .store_data_i      ( store_data      ),
        .trans_id_i        ( trans_id        ),
        .result_valid_o    ( result_valid    ),
        .result_trans_id_o ( result_trans_id ),
        .result_data_o     ( result_data     ),
        .ex_valid_o        ( ex_valid        ),
        .ex_cause_o        ( ex_cause        ),
        .ex_tval_o         ( ex_tval         ),
        .paddr_o           ( paddr           ),
        .psel_o            ( psel            ),
        .penable_o         ( penable         ),
        .pwrite_o          ( pwrite          ),
        .pwdata_o          ( pwdata          ),
        .pstrb_o           ( pstrb           ),
        .prdata_i          ( prdata          ),
        .pready_i          ( pready          ),
        .pslverr_i         ( pslverr         )
    );

    tb_apb_mem i_mem (
        .clk_i         ( clk       ),
        .rst_ni        ( rst_n     ),
        .paddr_i       ( paddr     ),
        .psel_i        ( psel      ),
        .penable_i     ( penable   ),
        .pwrite_i      ( pwrite    ),
        .pwdata_i      ( pwdata    ),
        .pstrb_i       ( pstrb     ),
        .prdata_o      ( prdata    ),
        .pready_o      ( pready    ),
        .pslverr_o     ( pslverr   ),
        .wait_states_i ( mem_wait  ),
        .error_i       ( mem_error )
    );

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_strobe(input string name, input be_t exp, input be_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_trans_id(input string name, input trans_id_t exp, input trans_id_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_cause(input string name, input cause_t exp, input cause_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        int         fd;
        int         latency;
        int         exp_latency;
        int         wait_v;
        string      line;
        string      lines[$];
        logic [3:0] op_code;
        addr_t      base_v;
        data_t      imm_v;
        data_t      wdata_v;
        trans_id_t  tid_v;
        logic       err_v;
        data_t      exp_data;
        logic       exp_ex;
        cause_t     exp_cause;
        logic       exp_mis;
        logic       saw_psel;

        void'($urandom(45985));
        rst_n      = 1'b0;
        lsu_valid  = 1'b0;
        op         = OP_LB;
        base       = '0;
        imm        = '0;
        store_data = '0;
        trans_id   = '0;
        mem_wait   = '0;
        mem_error  = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            stop_run();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
        if (lines.size() == 0) begin
            $display("the stimulus file holds no operations");
            stop_run();
        end
        n_ops = lines.size();

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_flag("lsu_ready_o", 1'b1, lsu_ready);
        check_flag("psel_o", 1'b0, psel);
        check_flag("penable_o", 1'b0, penable);
        check_flag("result_valid_o", 1'b0, result_valid);

        foreach (lines[i]) begin
            if ($sscanf(lines[i], "%h %h %h %h %h %d %h %h %h %h", op_code, base_v, imm_v,
                        wdata_v, tid_v, wait_v, err_v, exp_data, exp_ex, exp_cause) != 10) begin
                $display("stimulus entry %0d could not be parsed", i + 1);
                stop_run();
            end
            repeat ($urandom % 4) begin
                @(posedge clk);
                #2;
            end
            lsu_valid  = 1'b1;
            op         = lsu_op_e'(op_code);
            base       = base_v;
            imm        = imm_v;
            store_data = wdata_v;
            trans_id   = tid_v;
            mem_wait   = 8'(wait_v);
            mem_error  = err_v;
            // accepted on the next edge once ready is seen
            while (!lsu_ready) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2;
            lsu_valid = 1'b0;
            // issue bus no longer holds the accepted request
            op         = op_code[OP_STORE_BIT] ? OP_LB : OP_SW;
            base       = ~base_v;
            imm        = ~imm_v;
            store_data = ~wdata_v;
            trans_id   = ~tid_v;
            latency   = 1;
            saw_psel  = psel;
            check_flag("penable_o", 1'b0, penable);
            while (!result_valid) begin
                @(posedge clk);
                #2;
                latency  = latency + 1;
                saw_psel = saw_psel | psel;
                if (psel) begin
                    check_flag("pwrite_o", op_code[OP_STORE_BIT], pwrite);
                    if (!op_code[OP_STORE_BIT]) begin
                        check_strobe("pstrb_o", '0, pstrb);
                    end
                end
            end

            // misaligned ops skip the bus
            // slow ones are cut off by the timer
            exp_mis = exp_ex && (exp_cause == CAUSE_LD_MISALIGNED ||
                                 exp_cause == CAUSE_ST_MISALIGNED);
            if (exp_mis) begin
                exp_latency = 1;
            end else if (wait_v < ACCESS_TIMEOUT) begin
                exp_latency = 3 + wait_v;
            end else begin
                exp_latency = 2 + ACCESS_TIMEOUT;
            end

            check_trans_id("result_trans_id_o", tid_v, result_trans_id);
            check_flag("ex_valid_o", exp_ex, ex_valid);
            check_data("result_data_o", exp_data, result_data);
            if (exp_ex) begin
                check_cause("ex_cause_o", exp_cause, ex_cause);
            end
            check_addr("ex_tval_o", base_v + imm_v, ex_tval);
            check_flag("psel_o", !exp_mis, saw_psel);
            check_latency("result_valid_o latency", exp_latency, latency);
        end

        $display("** PASS **");
        $finish;
    end

    // worst case per op is one full timeout plus idle and handshake cycles
    initial begin
        wait (n_ops > 0);
        repeat (RESET_CYCLES + n_ops * (ACCESS_TIMEOUT + 10)) @(posedge clk);
        $display("the run timed out before all operations completed");
        stop_run();
    end

endmodule

`default_nettype wire

//--- verification/lsu_stimulus.txt
# op base imm store_data trans_id wait_states pslverr exp_data exp_ex exp_cause
# op codes 0 LB 1 LBU 2 LH 3 LHU 4 LW 8 SB a SH c SW; wait_states decimal, the rest hex
c 00000080 00000000 11223344 1 0 0 00000000 0 0
4 00000080 00000000 00000000 2 1 0 11223344 0 0
8 00000080 00000001 000000ab 3 0 0 00000000 0 0
a 00000084 fffffffe 0000cdef 4 2 0 00000000 0 0
4 00000080 00000000 00000000 5 0 0 cdefab44 0 0
c 000000a0 00000000 80f17f9c 6 3 0 00000000 0 0
0 000000a4 fffffffc 00000000 7 0 0 ffffff9c 0 0
1 000000a4 fffffffd 00000000 0 3 0 0000007f 0 0
0 000000a4 fffffffe 00000000 1 0 0 fffffff1 0 0
1 000000a4 ffffffff 00000000 2 4 0 00000080 0 0
0 000000a4 fffffffd 00000000 3 5 0 0000007f 0 0
1 000000a4 fffffffc 00000000 4 0 0 0000009c 0 0
0 000000a4 ffffffff 00000000 5 1 0 ffffff80 0 0
2 000000a4 fffffffc 00000000 6 0 0 00007f9c 0 0
2 000000a4 fffffffe 00000000 7 2 0 ffff80f1 0 0
3 000000a4 fffffffe 00000000 0 0 0 000080f1 0 0
3 000000a4 fffffffc 00000000 1 1 0 00007f9c 0 0
2 000000a0 00000003 00000000 2 0 0 00000000 1 4
4 000000a0 00000002 00000000 3 0 0 00000000 1 4
a 000000a0 00000001 0000ffff 4 0 0 00000000 1 6
c 000000a4 ffffffff ffffffff 5 0 0 00000000 1 6
4 000000a0 00000000 00000000 6 0 0 80f17f9c 0 0
4 000000a0 00000000 00000000 7 2 1 00000000 1 5
c 000000a0 00000000 12345678 0 0 1 00000000 1 7
4 000000a0 00000000 00000000 1 0 0 80f17f9c 0 0
4 000000c0 00000000 00000000 2 20 0 00000000 1 5
4 000000c0 00000000 00000000 3 0 0 5a5a00c0 0 0

//--- project.f
verilog/lsu_pkg.sv
verilog/lsu_agu.sv
verilog/lsu_wait_timer.sv
verilog/lsu_load_align.sv
verilog/lsu_access_fsm.sv
verilog/lsu_top.sv
verification/tb_apb_mem.sv
verification/tb_lsu.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_lsu \
    --Mdir obj_dir -o tb_lsu_sim

output=$(./obj_dir/tb_lsu_sim 2>&1 || true)
echo "$output"
echo "$output" | grep -qx '\*\* PASS \*\*'
